// File: fetch_pkg.sv
//////////////////////////////////////////////////
// fetch package
// shared widths, register offsets and reset PC
//////////////////////////////////////////////////
`default_nettype none

package fetch_pkg;

  typedef logic [63:0] pc_t;        // program counter / byte address
  typedef logic [31:0] inst_t;      // one instruction word
  typedef logic [3:0]  csr_addr_t;  // axi4-lite register offset
  typedef logic [31:0] csr_data_t;  // axi4-lite data word

  // register map
  localparam csr_addr_t CSR_CTRL  = 4'h0;  // bit 0 enable
  localparam csr_addr_t CSR_PC_LO = 4'h4;
  localparam csr_addr_t CSR_PC_HI = 4'h8;
  localparam csr_addr_t CSR_COUNT = 4'hC;  // read only

  // start PC after reset
  localparam pc_t PC_RESET = 64'h0000_0000_8000_0000;

endpackage

`default_nettype wire

// File: fetch_bus_if.sv
//////////////////////////////////////////////////
// instruction bus, request/acknowledge handshake
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

interface fetch_bus_if;

  logic             req;    // held until ack
  logic             ack;    // one cycle, rdata valid
  fetch_pkg::pc_t   addr;
  fetch_pkg::inst_t rdata;

  modport fetcher (
    output req, addr,
    input  ack, rdata
  );

  modport memory (
    input  req, addr,
    output ack, rdata
  );

endinterface

`default_nettype wire

// File: fetch_csr.sv
//////////////////////////////////////////////////
// axi4-lite register block for the fetch unit
// enable, start PC and delivered count
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module fetch_csr (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   i_awvalid,
  output logic                  o_awready,
  input  fetch_pkg::csr_addr_t  i_awaddr,
  input  wire                   i_wvalid,
  output logic                  o_wready,
  input  fetch_pkg::csr_data_t  i_wdata,
  output logic                  o_bvalid,
  input  wire                   i_bready,
  input  wire                   i_arvalid,
  output logic                  o_arready,
  input  fetch_pkg::csr_addr_t  i_araddr,
  output logic                  o_rvalid,
  input  wire                   i_rready,
  output fetch_pkg::csr_data_t  o_rdata,
  input  wire                   i_fetched,
  output logic                  o_enable,
  output fetch_pkg::pc_t        o_start_pc
);

  logic                 aw_seen, w_seen;
  fetch_pkg::csr_addr_t aw_addr_q;
  fetch_pkg::csr_data_t w_data_q;
  fetch_pkg::csr_data_t pc_lo, pc_hi, fetch_count;
  logic                 aw_hs, w_hs, ar_hs, have_aw, have_w;
  fetch_pkg::csr_addr_t wr_addr;
  fetch_pkg::csr_data_t wr_data;

  // no new address while a response waits
  assign o_awready = !aw_seen && !o_bvalid;
  assign o_wready  = !w_seen && !o_bvalid;
  assign o_arready = !o_rvalid;

  assign aw_hs   = i_awvalid && o_awready;
  assign w_hs    = i_wvalid && o_wready;
  assign ar_hs   = i_arvalid && o_arready;
  assign have_aw = aw_seen || aw_hs;
  assign have_w  = w_seen || w_hs;
  assign wr_addr = aw_seen ? aw_addr_q : i_awaddr;
  assign wr_data = w_seen ? w_data_q : i_wdata;

  assign o_start_pc = {pc_hi, pc_lo};

  //////////////////////////////////////////////////
  // write channel
  always_ff @(posedge clk) begin
    if (rst) begin
      aw_seen  <= 1'b0;
      w_seen   <= 1'b0;
      o_bvalid <= 1'b0;
      o_enable <= 1'b0;
      pc_lo    <= fetch_pkg::PC_RESET[31:0];
      pc_hi    <= fetch_pkg::PC_RESET[63:32];
    end else begin
      if (have_aw && have_w) begin
        aw_seen  <= 1'b0;
        w_seen   <= 1'b0;
        o_bvalid <= 1'b1;
        case (wr_addr)
          fetch_pkg::CSR_CTRL:  o_enable <= wr_data[0];
          fetch_pkg::CSR_PC_LO: pc_lo    <= wr_data;
          fetch_pkg::CSR_PC_HI: pc_hi    <= wr_data;
          default: ;  // count is read only
        endcase
      end else begin
        if (aw_hs) aw_seen <= 1'b1;
        if (w_hs) w_seen <= 1'b1;
        if (o_bvalid && i_bready) o_bvalid <= 1'b0;
      end
    end
  end

  // one half may arrive before the other
  always_ff @(posedge clk) begin
    if (aw_hs) aw_addr_q <= i_awaddr;
    if (w_hs) w_data_q <= i_wdata;
  end

  //////////////////////////////////////////////////
  // read channel and counter
  always_ff @(posedge clk) begin
    if (rst) begin
      o_rvalid    <= 1'b0;
      fetch_count <= '0;
    end else begin
      if (ar_hs) o_rvalid <= 1'b1;
      else if (o_rvalid && i_rready) o_rvalid <= 1'b0;
      if (i_fetched) fetch_count <= fetch_count + 32'd1;  // wraps
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      case (i_araddr)
        fetch_pkg::CSR_CTRL:  o_rdata <= {31'b0, o_enable};
        fetch_pkg::CSR_PC_LO: o_rdata <= pc_lo;
        fetch_pkg::CSR_PC_HI: o_rdata <= pc_hi;
        fetch_pkg::CSR_COUNT: o_rdata <= fetch_count;
        default:              o_rdata <= '0;
      endcase
    end
  end

  // write response held for the master
  a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    o_bvalid && !i_bready |=> o_bvalid);

endmodule

`default_nettype wire

// File: fetch_unit.sv
//////////////////////////////////////////////////
// instruction fetch, one request per retire
// jump redirect drops the stale word
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module fetch_unit (
  input  wire                clk,
  input  wire                rst,
  input  wire                i_enable,
  input  fetch_pkg::pc_t     i_start_pc,
  input  wire                i_retire,
  input  wire                i_jmp,
  input  fetch_pkg::pc_t     i_jmp_addr,
  fetch_bus_if.fetcher       bus,
  output fetch_pkg::pc_t     o_pc,
  output fetch_pkg::inst_t   o_inst,
  output logic               o_fetched
);

  logic           en_q;        // enable as last seen while idle
  logic           discard;     // drop the next returned word
  fetch_pkg::pc_t jmp_target;
  fetch_pkg::pc_t pred_pc;     // last delivered + 4
  logic           start;
  logic           handshake;
  logic           redirect;

  // enable edge only counts with no request in flight
  assign start     = i_enable && !en_q && !bus.req;
  assign handshake = bus.req && bus.ack;
  assign redirect  = i_jmp && (i_jmp_addr != pred_pc);

  //////////////////////////////////////////////////
  // request sequencing
  always_ff @(posedge clk) begin
    if (rst) begin
      en_q      <= 1'b0;
      discard   <= 1'b0;
      pred_pc   <= fetch_pkg::PC_RESET;
      bus.req   <= 1'b0;
      bus.addr  <= fetch_pkg::PC_RESET;
      o_fetched <= 1'b0;
    end else begin
      o_fetched <= 1'b0;
      if (!bus.req) en_q <= i_enable;

      if (start) begin
        bus.req  <= 1'b1;
        bus.addr <= i_start_pc;
        pred_pc  <= i_start_pc;
        discard  <= 1'b0;
      end else if (handshake) begin
        if (discard) begin
          // stale word, go straight to the target
          discard  <= 1'b0;
          bus.req  <= i_enable;
          bus.addr <= jmp_target;
          pred_pc  <= jmp_target;
        end else begin
          bus.req   <= 1'b0;
          bus.addr  <= bus.addr + 64'd4;
          pred_pc   <= bus.addr + 64'd4;
          o_fetched <= 1'b1;
        end
      end else if (i_retire && i_enable && en_q && !bus.req) begin
        bus.req <= 1'b1;  // next fetch after retire
      end

      // a jump seen in flight waits for the handshake
      if (redirect) discard <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // payload, no reset
  always_ff @(posedge clk) begin
    if (redirect) jmp_target <= i_jmp_addr;
    if (handshake && !discard) begin
      o_pc   <= bus.addr;
      o_inst <= bus.rdata;
    end
  end

  // the address holds until the rom answers
  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    bus.req && !bus.ack |=> bus.req && $stable(bus.addr));

  // one pulse per handshake, ack lasts one cycle
  a_fetched_pulse: assert property (@(posedge clk) disable iff (rst)
    o_fetched |=> !o_fetched);

endmodule

`default_nettype wire

// File: inst_rom.sv
//////////////////////////////////////////////////
// instruction rom with a random ack delay
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module inst_rom #(
  parameter int ROM_WORDS = 32
) (
  input  wire           clk,
  input  wire           rst,
  fetch_bus_if.memory   bus
);

  localparam int IDX_W = $clog2(ROM_WORDS);

  fetch_pkg::inst_t mem [ROM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic [3:0]       lfsr;      // x^4 + x^3 + 1
  logic [1:0]       wait_cnt;

  initial begin
    $readmemh("prog.hex", mem);
  end

  assign word_idx = bus.addr[IDX_W+1:2];  // wraps at ROM_WORDS

  // ack comes lfsr[1:0] + 1 cycles after req
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr     <= 4'h1;
      wait_cnt <= 2'd0;
      bus.ack  <= 1'b0;
    end else begin
      bus.ack <= 1'b0;
      if (bus.ack) begin
        wait_cnt <= 2'd0;
        lfsr     <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
      end else if (bus.req) begin
        if (wait_cnt == lfsr[1:0]) bus.ack <= 1'b1;
        else wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.req && !bus.ack) bus.rdata <= mem[word_idx];
  end

  // fetcher keeps req up through the ack
  a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    bus.ack |-> bus.req);

endmodule

`default_nettype wire

// File: fetch_top.sv
//////////////////////////////////////////////////
// fetch stage top: register block, fetch, rom
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module fetch_top #(
  parameter int ROM_WORDS = 32
) (
  input  wire                   clk,
  input  wire                   rst,
  // axi4-lite slave
  input  wire                   i_awvalid,
  output logic                  o_awready,
  input  fetch_pkg::csr_addr_t  i_awaddr,
  input  wire                   i_wvalid,
  output logic                  o_wready,
  input  fetch_pkg::csr_data_t  i_wdata,
  output logic                  o_bvalid,
  input  wire                   i_bready,
  output logic [1:0]            o_bresp,
  input  wire                   i_arvalid,
  output logic                  o_arready,
  input  fetch_pkg::csr_addr_t  i_araddr,
  output logic                  o_rvalid,
  input  wire                   i_rready,
  output fetch_pkg::csr_data_t  o_rdata,
  output logic [1:0]            o_rresp,
  // core side
  input  wire                   i_retire,
  input  wire                   i_jmp,
  input  fetch_pkg::pc_t        i_jmp_addr,
  output fetch_pkg::pc_t        o_pc,
  output fetch_pkg::inst_t      o_inst,
  output logic                  o_fetched
);

  logic           enable;
  fetch_pkg::pc_t start_pc;

  fetch_bus_if bus_if ();

  assign o_bresp = 2'b00;  // always OKAY
  assign o_rresp = 2'b00;

  fetch_csr fetch_csr_inst (
    .clk        (clk),
    .rst        (rst),
    .i_awvalid  (i_awvalid),
    .o_awready  (o_awready),
    .i_awaddr   (i_awaddr),
    .i_wvalid   (i_wvalid),
    .o_wready   (o_wready),
    .i_wdata    (i_wdata),
    .o_bvalid   (o_bvalid),
    .i_bready   (i_bready),
    .i_arvalid  (i_arvalid),
    .o_arready  (o_arready),
    .i_araddr   (i_araddr),
    .o_rvalid   (o_rvalid),
    .i_rready   (i_rready),
    .o_rdata    (o_rdata),
    .i_fetched  (o_fetched),
    .o_enable   (enable),
    .o_start_pc (start_pc)
  );

  fetch_unit fetch_unit_inst (
    .clk        (clk),
    .rst        (rst),
    .i_enable   (enable),
    .i_start_pc (start_pc),
    .i_retire   (i_retire),
    .i_jmp      (i_jmp),
    .i_jmp_addr (i_jmp_addr),
    .bus        (bus_if.fetcher),
    .o_pc       (o_pc),
    .o_inst     (o_inst),
    .o_fetched  (o_fetched)
  );

  inst_rom #(
    .ROM_WORDS (ROM_WORDS)
  ) inst_rom_inst (
    .clk (clk),
    .rst (rst),
    .bus (bus_if.memory)
  );

endmodule

`default_nettype wire

// File: tb_fetch_top.sv
//////////////////////////////////////////////////
// testbench for the fetch stage top
// random retire and jump side with a pc model
//////////////////////////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module tb_fetch_top;

  localparam int  NUM_FETCH   = 400;
  localparam int  WATCHDOG_NS = (NUM_FETCH * 40 + 500) * 20;
  localparam logic [63:0] ROM_BASE = 64'h0000_0000_8000_0000;
  localparam logic [63:0] START_PC = 64'h0000_0000_8000_0040;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 i_awvalid, o_awready, i_wvalid, o_wready, o_bvalid, i_bready;
  logic                 i_arvalid, o_arready, o_rvalid, i_rready;
  fetch_pkg::csr_addr_t i_awaddr, i_araddr;
  fetch_pkg::csr_data_t i_wdata, o_rdata, rd_data;
  logic [1:0]           o_bresp, o_rresp;
  logic                 i_retire, i_jmp, o_fetched;
  fetch_pkg::pc_t       i_jmp_addr, o_pc;
  fetch_pkg::inst_t     o_inst;

  logic [31:0] rng_state = 32'd68;
  logic        enable_written = 1'b0;
  int          pulse_count = 0;
  int          retire_count = 0;
  logic [63:0] pc_q[$];
  logic [31:0] inst_q[$];

  fetch_top #(.ROM_WORDS(32)) fetch_top_inst (
    .clk(clk), .rst(rst),
    .i_awvalid(i_awvalid), .o_awready(o_awready), .i_awaddr(i_awaddr),
    .i_wvalid(i_wvalid), .o_wready(o_wready), .i_wdata(i_wdata),
    .o_bvalid(o_bvalid), .i_bready(i_bready), .o_bresp(o_bresp),
    .i_arvalid(i_arvalid), .o_arready(o_arready), .i_araddr(i_araddr),
    .o_rvalid(o_rvalid), .i_rready(i_rready), .o_rdata(o_rdata), .o_rresp(o_rresp),
    .i_retire(i_retire), .i_jmp(i_jmp), .i_jmp_addr(i_jmp_addr),
    .o_pc(o_pc), .o_inst(o_inst), .o_fetched(o_fetched)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] rand_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // rom holds addi xi, x0, i at word i
  function automatic logic [31:0] expected_word(input logic [63:0] pc);
    logic [4:0] idx;
    idx = pc[6:2];
    return {7'b0, idx, 5'b0, 3'b0, idx, 7'h13};
  endfunction

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    abort_run();
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAIL at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic axi_write(input fetch_pkg::csr_addr_t a, input fetch_pkg::csr_data_t d);
    int cycles;
    cycles = 0;
    @(posedge clk);
    i_awvalid <= 1'b1;
    i_awaddr  <= a;
    i_wvalid  <= 1'b1;
    i_wdata   <= d;
    i_bready  <= 1'b1;
    do begin
      @(posedge clk);
      cycles++;
      if (i_awvalid && o_awready) i_awvalid <= 1'b0;
      if (i_wvalid && o_wready) i_wvalid <= 1'b0;
      assert (cycles < 20) else report_problem("axi write got no response");
    end while (!(o_bvalid && i_bready));
    check_value("o_bresp", o_bresp, 2'b00);  // OKAY
    i_bready <= 1'b0;
  endtask

  task automatic axi_read(input fetch_pkg::csr_addr_t a, output fetch_pkg::csr_data_t d);
    int cycles;
    cycles = 0;
    @(posedge clk);
    i_arvalid <= 1'b1;
    i_araddr  <= a;
    i_rready  <= 1'b1;
    do begin
      @(posedge clk);
      cycles++;
      if (i_arvalid && o_arready) i_arvalid <= 1'b0;
      assert (cycles < 20) else report_problem("axi read got no data");
    end while (!(o_rvalid && i_rready));
    check_value("o_rresp", o_rresp, 2'b00);  // OKAY
    d = o_rdata;
    i_rready <= 1'b0;
  endtask

  task automatic wait_pulse(output logic [63:0] pc, output logic [31:0] inst);
    int cycles;
    cycles = 0;
    while (pc_q.size() == 0) begin
      @(negedge clk);
      cycles++;
      assert (cycles < 400) else report_problem("fetch unit delivered nothing");
    end
    pc   = pc_q.pop_front();
    inst = inst_q.pop_front();
  endtask

  task automatic retire_one();
    @(posedge clk) i_retire <= 1'b1;
    @(posedge clk) i_retire <= 1'b0;
  endtask

  //////////////////////////////////////////////////
  // pulse monitor, one pulse per retire at most
  always @(posedge clk) begin
    if (!rst) begin
      if (!enable_written) check_value("o_fetched", o_fetched, 1'b0);
      if (o_fetched) begin
        pulse_count++;
        assert (pulse_count <= retire_count + 1)
          else report_problem("fetched pulse arrived without a retire");
        pc_q.push_back(o_pc);
        inst_q.push_back(o_inst);
      end
      if (i_retire) retire_count++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    report_problem("watchdog timeout, the run did not finish");
  end

  //////////////////////////////////////////////////
  // main sequence
  initial begin
    logic [63:0] model_pc, next_pc, tgt, got_pc;
    logic [31:0] r, got_inst;
    rst = 1'b1;
    {i_awvalid, i_wvalid, i_bready, i_arvalid, i_rready} = '0;
    i_awaddr = '0;
    i_araddr = '0;
    i_wdata  = '0;
    {i_retire, i_jmp} = '0;
    i_jmp_addr = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (5) @(posedge clk);

    axi_write(fetch_pkg::CSR_PC_LO, START_PC[31:0]);
    axi_write(fetch_pkg::CSR_PC_HI, START_PC[63:32]);
    axi_read(fetch_pkg::CSR_PC_LO, rd_data);
    check_value("CSR_PC_LO", rd_data, START_PC[31:0]);
    axi_read(fetch_pkg::CSR_PC_HI, rd_data);
    check_value("CSR_PC_HI", rd_data, START_PC[63:32]);
    enable_written = 1'b1;
    axi_write(fetch_pkg::CSR_CTRL, 32'd1);
    axi_read(fetch_pkg::CSR_CTRL, rd_data);
    check_value("CSR_CTRL", rd_data, 32'd1);

    model_pc = START_PC;
    for (int n = 0; n < NUM_FETCH; n++) begin
      wait_pulse(got_pc, got_inst);
      check_value("o_pc", got_pc, model_pc);
      check_value("o_inst", got_inst, expected_word(model_pc));
      next_pc = model_pc + 64'd4;
      r = rand_next();
      // last fetch stays plain so its request outlives the disable
      if (r[31:30] == 2'd0 && n < NUM_FETCH - 1) begin
        // half the targets match the prediction
        tgt = r[29] ? next_pc : ROM_BASE + {57'b0, r[20:16], 2'b00};
        @(posedge clk);
        i_jmp      <= 1'b1;
        i_jmp_addr <= tgt;
        @(posedge clk) i_jmp <= 1'b0;
        if (tgt != next_pc) next_pc = tgt;
      end
      repeat (r[25:24]) @(posedge clk);
      retire_one();
      model_pc = next_pc;
    end

    // disable, the request in flight still lands
    pc_q.delete();
    inst_q.delete();
    axi_write(fetch_pkg::CSR_CTRL, 32'd0);
    repeat (25) retire_one();
    check_value("pulses after disable", pc_q.size(), 1);
    wait_pulse(got_pc, got_inst);
    check_value("o_pc", got_pc, model_pc);
    check_value("o_inst", got_inst, expected_word(model_pc));

    axi_read(fetch_pkg::CSR_COUNT, rd_data);
    check_value("CSR_COUNT", rd_data, NUM_FETCH + 1);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
fetch_pkg.sv
fetch_bus_if.sv
fetch_csr.sv
fetch_unit.sv
inst_rom.sv
fetch_top.sv
tb_fetch_top.sv

// File: run.sh
#!/bin/sh
# build and run the fetch stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_fetch_top
./obj_dir/Vtb_fetch_top > sim.log 2>&1 || true
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
grep -q "NO ERRORS" sim.log

// File: prog.hex
00000013
00100093
00200113
00300193
00400213
00500293
00600313
00700393
00800413
00900493
00A00513
00B00593
00C00613
00D00693
00E00713
00F00793
01000813
01100893
01200913
01300993
01400A13
01500A93
01600B13
01700B93
01800C13
01900C93
01A00D13
01B00D93
01C00E13
01D00E93
01E00F13
01F00F93
